// File: verilog/sv39_pkg.sv
package sv39_pkg;

    // Address and page geometry
    typedef logic [38:0] vaddr_t;
    typedef logic [55:0] paddr_t;
    typedef logic [43:0] ppn_t;
    typedef logic [8:0]  vpn_part_t;
    typedef logic [26:0] vpn_t;        // TLB tag, VPN[2:0]
    typedef logic [11:0] page_offset_t;
    typedef logic [63:0] pte_word_t;

    localparam int PTE_BYTES        = 8;
    localparam int PAGE_OFFSET_BITS = 12;

    // Page table entry, bit 0 is V
    typedef struct packed {
        logic [9:0] reserved;
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    typedef logic [1:0] priv_t;
    localparam priv_t PRIV_U = 2'b00;
    localparam priv_t PRIV_S = 2'b01;
    localparam priv_t PRIV_M = 2'b11;

    typedef logic [63:0] satp_t;
    localparam logic [3:0] SATP_MODE_BARE = 4'h0;
    localparam logic [3:0] SATP_MODE_SV39 = 4'h8;
    localparam int SATP_MODE_MSB = 63;
    localparam int SATP_MODE_LSB = 60;
    localparam int SATP_PPN_MSB  = 43;
    localparam int SATP_PPN_LSB  = 0;

    // Level 2 is the root table, level 0 maps 4 KiB
    typedef logic [1:0] level_t;

    function automatic vpn_part_t vpn_slice(vaddr_t va, level_t lvl);
        case (lvl)
            2'd2:    return va[38:30];
            2'd1:    return va[29:21];
            default: return va[20:12];
        endcase
    endfunction

    function automatic logic [3:0] satp_mode(satp_t s);
        return s[SATP_MODE_MSB:SATP_MODE_LSB];
    endfunction

    function automatic ppn_t satp_ppn(satp_t s);
        return s[SATP_PPN_MSB:SATP_PPN_LSB];
    endfunction

endpackage

// File: verilog/mmu_pkg.sv
package mmu_pkg;

    // Request as captured from the core port
    typedef struct packed {
        sv39_pkg::vaddr_t vaddr;
        logic             write;
    } req_t;

    // One translation, as cached in the TLB
    typedef struct packed {
        sv39_pkg::ppn_t   ppn;
        sv39_pkg::level_t level;   // Level of the leaf PTE
        logic             u;
        logic             r;
        logic             w;
        logic             x;
    } leaf_t;

    typedef struct packed {
        leaf_t leaf;
        logic  bypass;             // No translation, M mode or Bare
        logic  walk_fault;
    } check_in_t;

    typedef struct packed {
        sv39_pkg::paddr_t paddr;
        logic             page_fault;
    } result_t;

    typedef enum logic [2:0] {
        FRONT_IDLE,
        FRONT_LOOKUP,
        FRONT_WALK,
        FRONT_CHECK,
        FRONT_HOLD
    } front_state_e;

    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_REQ,
        WALK_WAIT_LOW,
        WALK_DONE
    } walk_state_e;

endpackage

// File: verilog/mmu_front.sv
`timescale 1ns/1ps

module mmu_front (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  sv39_pkg::vaddr_t    virt_addr,
    input  logic                write,
    output logic                ack,
    output sv39_pkg::paddr_t    phys_addr,
    output logic                page_fault,
    input  sv39_pkg::satp_t     satp,
    input  sv39_pkg::priv_t     priv,
    output sv39_pkg::vpn_t      lookup_vpn,
    input  logic                tlb_hit,
    input  mmu_pkg::leaf_t      tlb_leaf,
    output logic                walk_start,
    output sv39_pkg::vaddr_t    walk_vaddr,
    input  logic                walk_done,
    input  mmu_pkg::leaf_t      walk_leaf,
    input  logic                walk_fault,
    output logic                check_valid,
    output mmu_pkg::check_in_t  check_in,
    output mmu_pkg::req_t       check_req,
    input  logic                result_valid,
    input  mmu_pkg::result_t    result
);

    mmu_pkg::front_state_e state;
    mmu_pkg::req_t         req_q;
    mmu_pkg::check_in_t    check_q;
    logic                  check_pulse;   // Check start for bypass and hit
    logic                  bypass;

    assign bypass = (priv == sv39_pkg::PRIV_M) ||
                    (sv39_pkg::satp_mode(satp) == sv39_pkg::SATP_MODE_BARE);

    assign lookup_vpn = req_q.vaddr[38:12];
    assign walk_vaddr = req_q.vaddr;
    assign check_req  = req_q;

    // Walk result goes straight to the check in the walk_done cycle
    assign check_valid = check_pulse || (state == mmu_pkg::FRONT_WALK && walk_done);
    assign check_in    = (state == mmu_pkg::FRONT_WALK) ?
                         mmu_pkg::check_in_t'{leaf: walk_leaf, bypass: 1'b0,
                                              walk_fault: walk_fault} : check_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= mmu_pkg::FRONT_IDLE;
            check_pulse <= 1'b0;
            walk_start  <= 1'b0;
            ack         <= 1'b0;
        end else begin
            check_pulse <= 1'b0;
            walk_start  <= 1'b0;
            case (state)
                mmu_pkg::FRONT_IDLE: begin
                    if (req) begin
                        state       <= bypass ? mmu_pkg::FRONT_CHECK : mmu_pkg::FRONT_LOOKUP;
                        check_pulse <= bypass;
                    end
                end
                mmu_pkg::FRONT_LOOKUP: begin
                    if (tlb_hit) begin
                        state       <= mmu_pkg::FRONT_CHECK;
                        check_pulse <= 1'b1;
                    end else begin
                        state      <= mmu_pkg::FRONT_WALK;
                        walk_start <= 1'b1;
                    end
                end
                mmu_pkg::FRONT_WALK: begin
                    if (walk_done) state <= mmu_pkg::FRONT_CHECK;
                end
                mmu_pkg::FRONT_CHECK: begin
                    if (result_valid) begin
                        ack   <= 1'b1;
                        state <= mmu_pkg::FRONT_HOLD;
                    end
                end
                mmu_pkg::FRONT_HOLD: begin
                    if (!req) begin   // Core has dropped req
                        ack   <= 1'b0;
                        state <= mmu_pkg::FRONT_IDLE;
                    end
                end
                default: state <= mmu_pkg::FRONT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mmu_pkg::FRONT_IDLE && req) begin
            req_q <= '{vaddr: virt_addr, write: write};
        end
        if (state == mmu_pkg::FRONT_IDLE && req && bypass) begin
            check_q <= '{leaf: '0, bypass: 1'b1, walk_fault: 1'b0};
        end else if (state == mmu_pkg::FRONT_LOOKUP) begin
            check_q <= '{leaf: tlb_leaf, bypass: 1'b0, walk_fault: 1'b0};
        end
        if (state == mmu_pkg::FRONT_CHECK && result_valid) begin
            phys_addr  <= result.paddr;
            page_fault <= result.page_fault;
        end
    end

    // Four-phase rule on the core side
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req));

endmodule

// File: verilog/sv39_tlb.sv
`timescale 1ns/1ps

module sv39_tlb #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic            clk,
    input  logic            rst_n,
    input  sv39_pkg::vpn_t  lookup_vpn,
    output logic            hit,
    output mmu_pkg::leaf_t  hit_leaf,
    input  logic            fill,
    input  mmu_pkg::leaf_t  fill_leaf,
    input  logic            flush
);

    localparam int IDX_BITS = $clog2(TLB_ENTRIES);

    logic [TLB_ENTRIES-1:0] valid_q;
    sv39_pkg::vpn_t         tag_q  [TLB_ENTRIES];
    mmu_pkg::leaf_t         leaf_q [TLB_ENTRIES];
    logic [IDX_BITS-1:0]    fill_ptr;
    logic [TLB_ENTRIES-1:0] match;

    // VPN parts below the leaf level are page offset for superpages
    function automatic sv39_pkg::vpn_t level_mask(sv39_pkg::level_t lvl);
        case (lvl)
            2'd2:    return {9'h1ff, 18'h0};
            2'd1:    return {18'h3ffff, 9'h0};
            default: return '1;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = valid_q[i] &&
                       (((tag_q[i] ^ lookup_vpn) & level_mask(leaf_q[i].level)) == '0);
        end
    end

    // One-hot select
    always_comb begin
        hit_leaf = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (match[i]) hit_leaf = hit_leaf | leaf_q[i];
        end
    end

    assign hit = |match;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;
            fill_ptr <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[fill_ptr] <= 1'b1;
            // Oldest fill goes first
            if (fill_ptr == IDX_BITS'(TLB_ENTRIES - 1)) fill_ptr <= '0;
            else                                        fill_ptr <= fill_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill && !flush) begin
            tag_q[fill_ptr]  <= lookup_vpn;
            leaf_q[fill_ptr] <= fill_leaf;
        end
    end

    // Fills only follow misses, so entries never overlap
    single_hit: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(match));

endmodule

// File: verilog/page_walker.sv
`timescale 1ns/1ps

module page_walker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  sv39_pkg::vaddr_t     vaddr,
    input  sv39_pkg::satp_t      satp,
    output logic                 done,
    output mmu_pkg::leaf_t       leaf,
    output logic                 fault,
    output logic                 mem_req,
    output sv39_pkg::paddr_t     mem_paddr,
    input  logic                 mem_ack,
    input  sv39_pkg::pte_word_t  mem_rdata
);

    mmu_pkg::walk_state_e state;
    sv39_pkg::level_t     level_q;
    sv39_pkg::ppn_t       base_ppn_q;   // Table being walked
    sv39_pkg::pte_t       pte_q;
    logic                 pte_leaf;
    logic                 pte_bad;
    logic                 misaligned;
    logic                 descend;
    logic                 walk_err;

    // PTE address from table base and this level's VPN slice
    assign mem_paddr = {base_ppn_q, {sv39_pkg::PAGE_OFFSET_BITS{1'b0}}} +
                       sv39_pkg::paddr_t'(sv39_pkg::vpn_slice(vaddr, level_q)) *
                       sv39_pkg::paddr_t'(sv39_pkg::PTE_BYTES);

    assign pte_leaf = pte_q.r || pte_q.x;
    assign pte_bad  = !pte_q.v || (pte_q.w && !pte_q.r);

    always_comb begin
        case (level_q)
            2'd2:    misaligned = |pte_q.ppn[17:0];  // 1 GiB
            2'd1:    misaligned = |pte_q.ppn[8:0];   // 2 MiB
            default: misaligned = 1'b0;
        endcase
    end

    assign descend  = !pte_bad && !pte_leaf && (level_q != 2'd0);
    assign walk_err = pte_bad || (pte_leaf && misaligned) ||
                      (!pte_leaf && level_q == 2'd0);

    assign done  = (state == mmu_pkg::WALK_DONE);
    assign fault = walk_err;
    assign leaf  = '{ppn: pte_q.ppn, level: level_q, u: pte_q.u,
                     r: pte_q.r, w: pte_q.w, x: pte_q.x};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= mmu_pkg::WALK_IDLE;
            level_q <= 2'd2;
            mem_req <= 1'b0;
        end else begin
            case (state)
                mmu_pkg::WALK_IDLE: begin
                    if (start) begin
                        level_q <= 2'd2;
                        mem_req <= 1'b1;
                        state   <= mmu_pkg::WALK_REQ;
                    end
                end
                mmu_pkg::WALK_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= mmu_pkg::WALK_WAIT_LOW;
                    end
                end
                mmu_pkg::WALK_WAIT_LOW: begin
                    // Memory must release ack before the next read
                    if (!mem_ack) begin
                        if (descend) begin
                            level_q <= level_q - 2'd1;
                            mem_req <= 1'b1;
                            state   <= mmu_pkg::WALK_REQ;
                        end else begin
                            state <= mmu_pkg::WALK_DONE;
                        end
                    end
                end
                mmu_pkg::WALK_DONE: state <= mmu_pkg::WALK_IDLE;
                default:            state <= mmu_pkg::WALK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mmu_pkg::WALK_IDLE && start) begin
            base_ppn_q <= sv39_pkg::satp_ppn(satp);
        end else if (state == mmu_pkg::WALK_WAIT_LOW && !mem_ack && descend) begin
            base_ppn_q <= pte_q.ppn;           // Next level table
        end
        if (state == mmu_pkg::WALK_REQ && mem_ack) begin
            pte_q <= sv39_pkg::pte_t'(mem_rdata);
        end
    end

    mem_paddr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && !mem_ack) |=> $stable(mem_paddr));

endmodule

// File: verilog/access_check.sv
`timescale 1ns/1ps

module access_check (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid,
    input  mmu_pkg::check_in_t  check_in,
    input  mmu_pkg::req_t       req,
    input  sv39_pkg::priv_t     priv,
    input  logic                sum,
    input  logic                mxr,
    output logic                result_valid,
    output mmu_pkg::result_t    result
);

    mmu_pkg::leaf_t   leaf;
    sv39_pkg::ppn_t   ppn_eff;
    logic             perm_fault;
    sv39_pkg::paddr_t paddr;
    logic             fault;

    assign leaf = check_in.leaf;

    // Superpages take the lower VPN parts from the virtual address
    always_comb begin
        case (leaf.level)
            2'd2: ppn_eff = {leaf.ppn[43:18],
                             sv39_pkg::vpn_slice(req.vaddr, 2'd1),
                             sv39_pkg::vpn_slice(req.vaddr, 2'd0)};
            2'd1: ppn_eff = {leaf.ppn[43:9], sv39_pkg::vpn_slice(req.vaddr, 2'd0)};
            default: ppn_eff = leaf.ppn;
        endcase
    end

    always_comb begin
        perm_fault = 1'b0;
        if (priv == sv39_pkg::PRIV_U && !leaf.u) perm_fault = 1'b1;
        if (priv == sv39_pkg::PRIV_S && leaf.u && !sum) perm_fault = 1'b1;
        if (req.write) begin
            if (!leaf.w) perm_fault = 1'b1;
        end else if (!(leaf.r || (leaf.x && mxr))) begin
            perm_fault = 1'b1;     // Execute-only needs MXR
        end
    end

    always_comb begin
        if (check_in.bypass) begin
            fault = 1'b0;
            paddr = sv39_pkg::paddr_t'(req.vaddr);   // Zero-extended
        end else if (check_in.walk_fault || perm_fault) begin
            fault = 1'b1;
            paddr = '0;
        end else begin
            fault = 1'b0;
            paddr = {ppn_eff, req.vaddr[sv39_pkg::PAGE_OFFSET_BITS-1:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) result_valid <= 1'b0;
        else        result_valid <= valid;
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            result.paddr      <= paddr;
            result.page_fault <= fault;
        end
    end

endmodule

// File: verilog/mmu_top.sv
`timescale 1ns/1ps

module mmu_top #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req,
    input  sv39_pkg::vaddr_t     virt_addr,
    input  logic                 write,
    output logic                 ack,
    output sv39_pkg::paddr_t     phys_addr,
    output logic                 page_fault,
    input  sv39_pkg::satp_t      satp,
    input  sv39_pkg::priv_t      priv,
    input  logic                 mstatus_sum,
    input  logic                 mstatus_mxr,
    input  logic                 tlb_flush,
    output logic                 mem_req,
    output sv39_pkg::paddr_t     mem_paddr,
    input  logic                 mem_ack,
    input  sv39_pkg::pte_word_t  mem_rdata
);

    sv39_pkg::vpn_t     lookup_vpn;
    logic               tlb_hit;
    mmu_pkg::leaf_t     tlb_leaf;
    logic               walk_start;
    sv39_pkg::vaddr_t   walk_vaddr;
    logic               walk_done;
    mmu_pkg::leaf_t     walk_leaf;
    logic               walk_fault;
    logic               tlb_fill;
    logic               check_valid;
    mmu_pkg::check_in_t check_in;
    mmu_pkg::req_t      check_req;
    logic               result_valid;
    mmu_pkg::result_t   result;

    assign tlb_fill = walk_done && !walk_fault;   // Faulting walks are not cached

    mmu_front u_front (
        .clk, .rst_n, .req, .virt_addr, .write, .ack, .phys_addr, .page_fault,
        .satp, .priv, .lookup_vpn, .tlb_hit, .tlb_leaf,
        .walk_start, .walk_vaddr, .walk_done, .walk_leaf, .walk_fault,
        .check_valid, .check_in, .check_req, .result_valid, .result
    );

    sv39_tlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb (
        .clk, .rst_n, .lookup_vpn,
        .hit(tlb_hit), .hit_leaf(tlb_leaf),
        .fill(tlb_fill), .fill_leaf(walk_leaf), .flush(tlb_flush)
    );

    page_walker u_walker (
        .clk, .rst_n, .start(walk_start), .vaddr(walk_vaddr), .satp,
        .done(walk_done), .leaf(walk_leaf), .fault(walk_fault),
        .mem_req, .mem_paddr, .mem_ack, .mem_rdata
    );

    access_check u_check (
        .clk, .rst_n, .valid(check_valid), .check_in, .req(check_req), .priv,
        .sum(mstatus_sum), .mxr(mstatus_mxr), .result_valid, .result
    );

endmodule

// File: testbench/tb_pt_memory.sv
`timescale 1ns/1ps

module tb_pt_memory (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mem_req,
    input  sv39_pkg::paddr_t     mem_paddr,
    output logic                 mem_ack,
    output sv39_pkg::pte_word_t  mem_rdata,
    output int                   reads
);

    localparam int WORDS = 4096;        // 32 KiB from physical address 0

    sv39_pkg::pte_word_t words [WORDS];
    logic [15:0]         lfsr = 16'd65;
    logic [1:0]          delay_bits;
    logic [1:0]          wait_left;
    logic                waiting;      // Delay drawn for the current read

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic sv39_pkg::pte_word_t read_word(sv39_pkg::paddr_t pa);
        if (pa[55:15] != '0) return '0;   // Reads as an invalid PTE
        return words[pa[14:3]];
    endfunction

    task automatic clear_words();
        for (int i = 0; i < WORDS; i++) begin
            words[i] = '0;
        end
    endtask

    // Returns 0 when the address lies outside the model
    function automatic logic load_word(sv39_pkg::paddr_t pa, sv39_pkg::pte_word_t data);
        if (pa[55:15] != '0) return 1'b0;
        words[pa[14:3]] = data;
        return 1'b1;
    endfunction

    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ack   <= 1'b0;
            mem_rdata <= '0;
            reads     <= 0;
            wait_left <= '0;
            waiting   <= 1'b0;
        end else if (mem_req && !mem_ack) begin
            if (!waiting) begin
                for (int i = 0; i < 2; i++) begin
                    delay_bits[i] = lfsr[0];
                    lfsr = lfsr_next(lfsr);
                end
                wait_left <= delay_bits;
                waiting   <= 1'b1;
            end else if (wait_left == '0) begin
                mem_ack   <= 1'b1;
                mem_rdata <= read_word(mem_paddr);
                reads     <= reads + 1;
                waiting   <= 1'b0;
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end else if (!mem_req && mem_ack) begin
            mem_ack <= 1'b0;      // Walker has taken the data
        end
    end

endmodule

// File: testbench/tb_mmu.sv
`timescale 1ns/1ps

module tb_mmu;

    localparam int             MAX_PATTERNS = 64;
    localparam sv39_pkg::ppn_t ROOT_PPN     = 44'h1;   // Root table at 0x1000

    typedef struct packed {
        logic [8*24-1:0]  name;
        sv39_pkg::priv_t  priv;
        logic [3:0]       mode;
        logic             sum;
        logic             mxr;
        logic             write;
        sv39_pkg::vaddr_t vaddr;
        logic             flush;
        sv39_pkg::paddr_t exp_paddr;
        logic             exp_fault;
        logic [7:0]       exp_reads;
    } pattern_t;

    logic                clk;
    logic                rst_n;
    logic                req;
    sv39_pkg::vaddr_t    virt_addr;
    logic                write;
    logic                ack;
    sv39_pkg::paddr_t    phys_addr;
    logic                page_fault;
    sv39_pkg::satp_t     satp;
    sv39_pkg::priv_t     priv;
    logic                mstatus_sum;
    logic                mstatus_mxr;
    logic                tlb_flush;
    logic                mem_req;
    sv39_pkg::paddr_t    mem_paddr;
    logic                mem_ack;
    sv39_pkg::pte_word_t mem_rdata;
    int                  mem_reads;

    pattern_t patterns [MAX_PATTERNS];
    int       n_patterns;
    int       errors;
    int       checks;
    logic     loaded;

    mmu_top #(.TLB_ENTRIES(8)) u_dut (
        .clk, .rst_n, .req, .virt_addr, .write, .ack, .phys_addr, .page_fault,
        .satp, .priv, .mstatus_sum, .mstatus_mxr, .tlb_flush,
        .mem_req, .mem_paddr, .mem_ack, .mem_rdata
    );

    tb_pt_memory u_mem (
        .clk, .rst_n, .mem_req, .mem_paddr, .mem_ack, .mem_rdata, .reads(mem_reads)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input logic [8*24-1:0] test, input logic [8*8-1:0] what,
                               input logic [63:0] expected, input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error %0s %0s: expected %0h, actual %0h", test, what, expected, actual);
        end
    endtask

    task automatic load_patterns();
        int               fd;
        int               code;
        logic [8*8-1:0]   tag;
        logic [8*200-1:0] rest;
        logic [8*24-1:0]  nm;
        logic [63:0]      v [10];
        pattern_t         p;
        fd = $fopen("testbench/mmu_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open testbench/mmu_patterns.txt");
        end else begin
            u_mem.clear_words();
            while (1) begin
                code = $fscanf(fd, "%s", tag);
                if (code != 1) break;
                if (tag == "m") begin
                    code = $fscanf(fd, "%h %h", v[0], v[1]);
                    if (code != 2 || !u_mem.load_word(v[0][55:0], v[1])) begin
                        errors++;
                        $display("Memory line near address %0h is malformed or out of range",
                                 v[0]);
                    end
                end else if (tag == "r") begin
                    code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h", nm,
                                   v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
                    if (code != 11 || n_patterns == MAX_PATTERNS) begin
                        errors++;
                        $display("Request line %0d is malformed or over the limit", n_patterns);
                    end else begin
                        p.name      = nm;
                        p.priv      = v[0][1:0];
                        p.mode      = v[1][3:0];
                        p.sum       = v[2][0];
                        p.mxr       = v[3][0];
                        p.write     = v[4][0];
                        p.vaddr     = v[5][38:0];
                        p.flush     = v[6][0];
                        p.exp_paddr = v[7][55:0];
                        p.exp_fault = v[8][0];
                        p.exp_reads = v[9][7:0];
                        patterns[n_patterns] = p;
                        n_patterns++;
                    end
                end else begin
                    code = $fgets(rest, fd);   // Comment line
                end
            end
            $fclose(fd);
            if (n_patterns == 0) begin
                errors++;
                $display("Pattern file holds no requests");
            end
        end
    endtask

    task automatic run_pattern(input pattern_t p);
        int reads_before;
        @(negedge clk);
        satp        = {p.mode, 16'h0, ROOT_PPN};
        priv        = p.priv;
        mstatus_sum = p.sum;
        mstatus_mxr = p.mxr;
        if (p.flush) begin
            tlb_flush = 1'b1;
            @(negedge clk);
            tlb_flush = 1'b0;
        end
        reads_before = mem_reads;
        virt_addr    = p.vaddr;
        write        = p.write;
        req          = 1'b1;
        @(negedge clk);
        while (!ack) @(negedge clk);
        check_value(p.name, "paddr", 64'(p.exp_paddr), 64'(phys_addr));
        check_value(p.name, "fault", 64'(p.exp_fault), 64'(page_fault));
        check_value(p.name, "reads", 64'(p.exp_reads), 64'(mem_reads - reads_before));
        req = 1'b0;
        @(negedge clk);
        while (ack) @(negedge clk);
    endtask

    initial begin
        rst_n       = 1'b0;
        req         = 1'b0;
        virt_addr   = '0;
        write       = 1'b0;
        satp        = '0;
        priv        = sv39_pkg::PRIV_M;
        mstatus_sum = 1'b0;
        mstatus_mxr = 1'b0;
        tlb_flush   = 1'b0;
        n_patterns  = 0;
        errors      = 0;
        checks      = 0;
        loaded      = 1'b0;
        load_patterns();
        loaded = 1'b1;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_patterns; i++) begin
            run_pattern(patterns[i]);
        end
        repeat (2) @(negedge clk);
        $display("Mismatches: %0d, checks: %0d, patterns: %0d", errors, checks, n_patterns);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Budget of 60 cycles per request plus one spare
    initial begin
        wait (loaded);
        repeat ((n_patterns + 1) * 60) @(posedge clk);
        $display("Watchdog expired, a request or memory read never completed");
        $display("Errors found");
        $finish;
    end

endmodule

// File: testbench/mmu_patterns.txt
# m <pte address> <pte word>
# r <name> <priv> <satp mode> <sum> <mxr> <write> <vaddr> <flush> <exp paddr> <exp fault> <exp reads>
# Root table at 1000, level 1 table at 2000, level 0 table at 3000
m 1000 0000000000000801
m 1008 00000000200000c7
m 1010 00000000200004c7
m 1020 0000000040000005
m 2000 0000000000000c01
m 2008 00000000001000c7
m 2018 00000000001004c7
m 3000 00000000000400c7
m 3008 0000000000001401
m 3010 00000000000408d7
m 3018 0000000000040c49
m 3020 0000000000041043
m 3028 00000000000414c7
m 3030 00000000000418c7
m 3038 0000000000041cc7
m 3040 00000000000420c7
m 3048 00000000000424c7
m 3050 00000000000428c7
m 3058 0000000000042cc7
m 3060 00000000000430c7
m 3068 00000000000434c7
r byp_m_mode          3 8 0 0 0 7ffffff123 0 7ffffff123 0 0
r byp_bare            1 0 0 0 0 12345678 0 12345678 0 0
r walk_4k             1 8 0 0 0 abc 0 100abc 0 3
r hit_4k_write        1 8 0 0 1 123 0 100123 0 0
r walk_2m             1 8 0 0 0 203abc 0 403abc 0 2
r hit_2m_other        1 8 0 0 0 2ff123 0 4ff123 0 0
r walk_1g             1 8 0 0 0 41234567 0 81234567 0 1
r hit_1g_other        1 8 0 0 0 7ffff008 0 bffff008 0 0
r flt_invalid         1 8 0 0 0 c0000000 0 0 1 1
r flt_invalid_again   1 8 0 0 0 c0000000 0 0 1 1
r flt_w_no_r          1 8 0 0 0 100000000 0 0 1 1
r flt_misalign_1g     1 8 0 0 0 80000020 0 0 1 1
r flt_misalign_2m     1 8 0 0 0 600010 0 0 1 2
r flt_nonleaf_l0      1 8 0 0 0 1000 0 0 1 3
r flt_nonleaf_again   1 8 0 0 0 1000 0 0 1 3
r flt_user_on_s       0 8 0 0 0 0 0 0 1 0
r flt_s_no_sum        1 8 0 0 0 2040 0 0 1 3
r ok_s_with_sum       1 8 1 0 0 2040 0 102040 0 0
r ok_user_write       0 8 0 0 1 2048 0 102048 0 0
r flt_xonly_no_mxr    1 8 0 0 0 3008 0 0 1 3
r ok_xonly_mxr        1 8 0 1 0 3008 0 103008 0 0
r flt_ro_write        1 8 0 0 1 4010 0 0 1 3
r ok_ro_read          1 8 0 0 0 4010 0 104010 0 0
r flush_rewalk        1 8 0 0 0 abc 1 100abc 0 3
r evict_fill_p5       1 8 0 0 0 5000 1 105000 0 3
r evict_fill_p6       1 8 0 0 0 6000 0 106000 0 3
r evict_fill_p7       1 8 0 0 0 7000 0 107000 0 3
r evict_fill_p8       1 8 0 0 0 8000 0 108000 0 3
r evict_fill_p9       1 8 0 0 0 9000 0 109000 0 3
r evict_fill_p10      1 8 0 0 0 a000 0 10a000 0 3
r evict_fill_p11      1 8 0 0 0 b000 0 10b000 0 3
r evict_fill_p12      1 8 0 0 0 c000 0 10c000 0 3
r evict_fill_p13      1 8 0 0 0 d000 0 10d000 0 3
r evict_p13_hits      1 8 0 0 0 d800 0 10d800 0 0
r evict_p5_rewalk     1 8 0 0 0 5800 0 105800 0 3

// File: sources.f
verilog/sv39_pkg.sv
verilog/mmu_pkg.sv
verilog/mmu_front.sv
verilog/sv39_tlb.sv
verilog/page_walker.sv
verilog/access_check.sv
verilog/mmu_top.sv
testbench/tb_pt_memory.sv
testbench/tb_mmu.sv

// File: Bender.yml
package:
  name: sv39_mmu

sources:
  - verilog/sv39_pkg.sv
  - verilog/mmu_pkg.sv
  - verilog/mmu_front.sv
  - verilog/sv39_tlb.sv
  - verilog/page_walker.sv
  - verilog/access_check.sv
  - verilog/mmu_top.sv
  - target: test
    files:
      - testbench/tb_pt_memory.sv
      - testbench/tb_mmu.sv
